// File: source/trace_snoop_pkg.sv
//******************************
// Trace record format
// Field 0 sits in the low word and also
// carries the opcode in instruction mode
//******************************
`default_nettype none

package trace_snoop_pkg;

   // Words per record, one bank each
   localparam int unsigned num_fields_c = 5;

   // Width of one record field
   localparam int unsigned field_width_c = 32;

   // Declared from the top word down, so pc_src_l lands in bits [31:0]
   typedef struct packed {
      logic [field_width_c-1:0] metadata;
      logic [field_width_c-1:0] pc_dst_h;
      logic [field_width_c-1:0] pc_dst_l;
      logic [field_width_c-1:0] pc_src_h;
      logic [field_width_c-1:0] pc_src_l;
   } trace_t;

   // Snoop modes, both upper codes disable recording
   typedef enum logic [1:0] {
      MODE_ADDRESS     = 2'b00,
      MODE_INSTRUCTION = 2'b01,
      MODE_OFF_2       = 2'b10,
      MODE_OFF_3       = 2'b11
   } trace_mode_e;

endpackage

`default_nettype wire

// File: source/snoop_cfg_pkg.sv
//******************************
// Configuration register map
// CTRL holds mode [1:0] and cnt_rst [2]
// STATUS holds full [31] and cnt below
//******************************
`default_nettype none

package snoop_cfg_pkg;

   // Register select, only CTRL takes writes
   typedef enum logic {
      CFG_CTRL   = 1'b0,
      CFG_STATUS = 1'b1
   } cfg_sel_e;

   // Bit of the CTRL word that requests a counter reset
   localparam int unsigned cfg_ctrl_rst_bit_c = 2;

   // Bit of the STATUS word that shows the full flag
   localparam int unsigned cfg_status_full_bit_c = 31;

   // Control state handed to the engine
   typedef struct packed {
      trace_snoop_pkg::trace_mode_e trace_mode;
      logic                         cnt_rst;
   } snoop_cfg_t;

endpackage

`default_nettype wire

// File: source/snoop_cfg_regs.sv
//******************************
// Control and status registers
// cnt_rst is a one-cycle pulse after the write
// AddrWidth must stay below 31
//******************************
`timescale 1ns/1ns
`default_nettype none

module snoop_cfg_regs
   import trace_snoop_pkg::*;
   import snoop_cfg_pkg::*;
#(
   parameter int unsigned AddrWidth = 10
) (
   input  wire  logic                 clk_i,
   input  wire  logic                 rst_ni,
   input  wire  logic                 cfg_we_i,
   input  wire  cfg_sel_e             cfg_sel_i,
   input  wire  logic [31:0]          cfg_wdata_i,
   output       logic [31:0]          cfg_rdata_o,
   input  wire  logic                 buf_full_i,
   input  wire  logic [AddrWidth-1:0] cnt_i,
   output       snoop_cfg_t           cfg_o
);

   trace_mode_e mode_q;
   logic        cnt_rst_q;
   logic        ctrl_we;

   assign ctrl_we = cfg_we_i && (cfg_sel_i == CFG_CTRL);

   // Mode is stored, counter reset clears itself on the next edge
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         mode_q    <= MODE_OFF_3;
         cnt_rst_q <= 1'b0;
      end else begin
         cnt_rst_q <= ctrl_we && cfg_wdata_i[cfg_ctrl_rst_bit_c];
         if (ctrl_we) begin
            mode_q <= trace_mode_e'(cfg_wdata_i[1:0]);
         end
      end
   end

   assign cfg_o.trace_mode = mode_q;
   assign cfg_o.cnt_rst    = cnt_rst_q;

   // Read-back mux
   always_comb begin
      cfg_rdata_o = '0;
      case (cfg_sel_i)
         CFG_CTRL: begin
            cfg_rdata_o[1:0] = mode_q;
         end
         default: begin
            cfg_rdata_o[AddrWidth-1:0]          = cnt_i;
            cfg_rdata_o[cfg_status_full_bit_c] = buf_full_i;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: source/snooping_engine.sv
//******************************
// Snooping engine
// One entry per strobe, counter wraps at 2**AddrWidth
// A cnt_rst pulse drops a strobe in the same cycle
//******************************
`timescale 1ns/1ns
`default_nettype none

module snooping_engine
   import trace_snoop_pkg::*;
   import snoop_cfg_pkg::*;
#(
   parameter int unsigned AddrWidth = 10
) (
   input  wire  logic                                      clk_i,
   input  wire  logic                                      rst_ni,
   input  wire  trace_t                                    trace_i,
   input  wire  logic                                      snoop_en_i,
   input  wire  snoop_cfg_t                                cfg_i,
   output       logic [num_fields_c-1:0]                   bank_req_o,
   output       logic [num_fields_c-1:0][AddrWidth-1:0]     bank_addr_o,
   output       logic [num_fields_c-1:0][field_width_c-1:0] bank_wdata_o,
   output       logic [AddrWidth-1:0]                      cnt_o,
   output       logic [AddrWidth-1:0]                      first_valid_o,
   output       logic [AddrWidth-1:0]                      last_valid_o,
   output       logic                                      buf_full_o
);

   logic [num_fields_c-1:0][field_width_c-1:0] trace_words;
   logic                                       mode_active;
   logic                                       rec_write;
   logic                                       at_last_entry;
   logic [AddrWidth-1:0]                       cnt_next;

   // Record viewed as one word per bank, field 0 lowest
   assign trace_words = trace_i;

   assign mode_active = (cfg_i.trace_mode == MODE_ADDRESS) ||
                        (cfg_i.trace_mode == MODE_INSTRUCTION);
   assign rec_write   = snoop_en_i && mode_active && !cfg_i.cnt_rst;

   // Natural overflow gives the wrap at the bank depth
   assign cnt_next      = cnt_o + 1'b1;
   assign at_last_entry = (cnt_o == '1);

   // Bank select and field routing
   always_comb begin
      bank_req_o   = '0;
      bank_wdata_o = '0;
      for (int unsigned i = 0; i < num_fields_c; i++) begin
         bank_addr_o[i] = cnt_o;
      end
      if (rec_write) begin
         case (cfg_i.trace_mode)
            MODE_ADDRESS: begin
               bank_req_o   = '1;
               bank_wdata_o = trace_words;
            end
            MODE_INSTRUCTION: begin
               // Opcode only, other banks keep their old words
               bank_req_o[0]   = 1'b1;
               bank_wdata_o[0] = trace_words[0];
            end
            default: begin
               bank_req_o = '0;
            end
         endcase
      end
   end

   // Entry counter and valid window
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         cnt_o         <= '0;
         first_valid_o <= '0;
         last_valid_o  <= '0;
         buf_full_o    <= 1'b0;
      end else if (cfg_i.cnt_rst) begin
         cnt_o         <= '0;
         first_valid_o <= '0;
         last_valid_o  <= '0;
         buf_full_o    <= 1'b0;
      end else if (rec_write) begin
         cnt_o        <= cnt_next;
         last_valid_o <= cnt_o;
         // Oldest entry moves along once the buffer has wrapped
         if (buf_full_o || at_last_entry) begin
            first_valid_o <= cnt_next;
         end
         if (at_last_entry) begin
            buf_full_o <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: source/trace_bank.sv
//******************************
// One field bank, 2**AddrWidth words
// Read data appears one cycle after rd_req_i
// Same-entry read and write returns old data
//******************************
`timescale 1ns/1ns
`default_nettype none

module trace_bank #(
   parameter int unsigned AddrWidth = 10
) (
   input  wire  logic                 clk_i,
   input  wire  logic                 rst_ni,
   input  wire  logic                 wr_req_i,
   input  wire  logic [AddrWidth-1:0] wr_addr_i,
   input  wire  logic [31:0]          wr_data_i,
   input  wire  logic                 rd_req_i,
   input  wire  logic [AddrWidth-1:0] rd_addr_i,
   output       logic [31:0]          rd_data_o
);

   logic [31:0] mem [2**AddrWidth];

   always_ff @(posedge clk_i) begin
      if (wr_req_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // Registered read port, holds its value between requests
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         rd_data_o <= '0;
      end else if (rd_req_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

`default_nettype wire

// File: source/trace_readout.sv
//******************************
// Readout of one entry from all banks
// rd_valid_o follows rd_req_i by one cycle
// A request may come every cycle
//******************************
`timescale 1ns/1ns
`default_nettype none

module trace_readout
   import trace_snoop_pkg::*;
#(
   parameter int unsigned AddrWidth = 10
) (
   input  wire  logic                         clk_i,
   input  wire  logic                         rst_ni,
   input  wire  logic                         rd_req_i,
   input  wire  logic [AddrWidth-1:0]         rd_entry_i,
   output       logic                         bank_rd_req_o,
   output       logic [AddrWidth-1:0]         bank_rd_addr_o,
   input  wire  logic [num_fields_c-1:0][31:0] bank_rd_data_i,
   output       logic                         rd_valid_o,
   output       trace_t                       rd_data_o
);

   logic rd_valid_q;

   // Same entry index goes to every bank
   assign bank_rd_req_o  = rd_req_i;
   assign bank_rd_addr_o = rd_entry_i;

   // Matches the registered bank read
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         rd_valid_q <= 1'b0;
      end else begin
         rd_valid_q <= rd_req_i;
      end
   end

   assign rd_valid_o = rd_valid_q;

   // Bank words into record fields
   always_comb begin
      rd_data_o.pc_src_l = bank_rd_data_i[0];
      rd_data_o.pc_src_h = bank_rd_data_i[1];
      rd_data_o.pc_dst_l = bank_rd_data_i[2];
      rd_data_o.pc_dst_h = bank_rd_data_i[3];
      rd_data_o.metadata = bank_rd_data_i[4];
   end

endmodule

`default_nettype wire

// File: source/trace_snooper.sv
//******************************
// Trace snooper top
// Buffer depth is 2**AddrWidth entries
// Oldest entries are overwritten, no stall
//******************************
`timescale 1ns/1ns
`default_nettype none

module trace_snooper
   import trace_snoop_pkg::*;
   import snoop_cfg_pkg::*;
#(
   parameter int unsigned AddrWidth = 10
) (
   input  wire  logic                 clk_i,
   input  wire  logic                 rst_ni,
   input  wire  logic                 cfg_we_i,
   input  wire  cfg_sel_e             cfg_sel_i,
   input  wire  logic [31:0]          cfg_wdata_i,
   output       logic [31:0]          cfg_rdata_o,
   input  wire  trace_t               trace_i,
   input  wire  logic                 snoop_en_i,
   input  wire  logic                 rd_req_i,
   input  wire  logic [AddrWidth-1:0] rd_entry_i,
   output       logic                 rd_valid_o,
   output       trace_t               rd_data_o,
   output       logic [AddrWidth-1:0] cnt_o,
   output       logic [AddrWidth-1:0] first_valid_o,
   output       logic [AddrWidth-1:0] last_valid_o
);

   snoop_cfg_t                                 cfg;
   logic                                       buf_full;
   logic [num_fields_c-1:0]                    bank_req;
   logic [num_fields_c-1:0][AddrWidth-1:0]     bank_addr;
   logic [num_fields_c-1:0][field_width_c-1:0] bank_wdata;
   logic                                       bank_rd_req;
   logic [AddrWidth-1:0]                       bank_rd_addr;
   logic [num_fields_c-1:0][31:0]              bank_rd_data;

   snoop_cfg_regs #(
      .AddrWidth(AddrWidth)
   ) u_cfg_regs (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .cfg_we_i    (cfg_we_i),
      .cfg_sel_i   (cfg_sel_i),
      .cfg_wdata_i (cfg_wdata_i),
      .cfg_rdata_o (cfg_rdata_o),
      .buf_full_i  (buf_full),
      .cnt_i       (cnt_o),
      .cfg_o       (cfg)
   );

   snooping_engine #(
      .AddrWidth(AddrWidth)
   ) u_engine (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .trace_i       (trace_i),
      .snoop_en_i    (snoop_en_i),
      .cfg_i         (cfg),
      .bank_req_o    (bank_req),
      .bank_addr_o   (bank_addr),
      .bank_wdata_o  (bank_wdata),
      .cnt_o         (cnt_o),
      .first_valid_o (first_valid_o),
      .last_valid_o  (last_valid_o),
      .buf_full_o    (buf_full)
   );

   // One bank per record field
   for (genvar b = 0; b < num_fields_c; b++) begin : gen_bank
      trace_bank #(
         .AddrWidth(AddrWidth)
      ) u_bank (
         .clk_i     (clk_i),
         .rst_ni    (rst_ni),
         .wr_req_i  (bank_req[b]),
         .wr_addr_i (bank_addr[b]),
         .wr_data_i (bank_wdata[b]),
         .rd_req_i  (bank_rd_req),
         .rd_addr_i (bank_rd_addr),
         .rd_data_o (bank_rd_data[b])
      );
   end

   trace_readout #(
      .AddrWidth(AddrWidth)
   ) u_readout (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .rd_req_i       (rd_req_i),
      .rd_entry_i     (rd_entry_i),
      .bank_rd_req_o  (bank_rd_req),
      .bank_rd_addr_o (bank_rd_addr),
      .bank_rd_data_i (bank_rd_data),
      .rd_valid_o     (rd_valid_o),
      .rd_data_o      (rd_data_o)
   );

endmodule

`default_nettype wire

// File: sim/trace_snooper_checker.sv
//******************************
// Trace snooper assertions
// Bound at the top level, where engine and readout meet
// Checks hold only while rst_ni is high
//******************************
`timescale 1ns/1ns
`default_nettype none

module trace_snooper_checker
   import trace_snoop_pkg::*;
   import snoop_cfg_pkg::*;
#(
   parameter int unsigned AddrWidth = 10
) (
   input  wire  logic                    clk_i,
   input  wire  logic                    rst_ni,
   input  wire  logic [AddrWidth-1:0]    cnt_i,
   input  wire  logic [AddrWidth-1:0]    first_valid_i,
   input  wire  logic                    buf_full_i,
   input  wire  snoop_cfg_t              cfg_i,
   input  wire  logic [num_fields_c-1:0] bank_req_i,
   input  wire  logic                    rd_req_i,
   input  wire  logic                    rd_valid_i
);

   // Assertion failures so far
   int fail_cnt = 0;

   // Counter reaches 0 only by wrapping from the last entry or by cnt_rst
   a_cnt_wrap: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (cnt_i != '0) && (cnt_i != '1) && !cfg_i.cnt_rst |=> (cnt_i != '0))
      else begin
         fail_cnt++;
         $error("cnt_o dropped to 0 before the last entry");
      end

   a_first_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
      buf_full_i |-> (first_valid_i == cnt_i))
      else begin
         fail_cnt++;
         $error("first_valid_o differs from cnt_o while full");
      end

   // Valid follows a request by one cycle and never comes alone
   a_rd_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rd_req_i |=> rd_valid_i)
      else begin
         fail_cnt++;
         $error("rd_valid_o missing one cycle after rd_req_i");
      end

   a_rd_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !rd_req_i |=> !rd_valid_i)
      else begin
         fail_cnt++;
         $error("rd_valid_o high without a request");
      end

   a_off_mode: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (cfg_i.trace_mode == MODE_OFF_2 || cfg_i.trace_mode == MODE_OFF_3)
      |-> (bank_req_i == '0))
      else begin
         fail_cnt++;
         $error("bank request raised in an off mode");
      end

endmodule

bind trace_snooper trace_snooper_checker #(
   .AddrWidth(AddrWidth)
) u_checker (
   .clk_i         (clk_i),
   .rst_ni        (rst_ni),
   .cnt_i         (cnt_o),
   .first_valid_i (first_valid_o),
   .buf_full_i    (buf_full),
   .cfg_i         (cfg),
   .bank_req_i    (bank_req),
   .rd_req_i      (rd_req_i),
   .rd_valid_i    (rd_valid_o)
);

`default_nettype wire

// File: sim/trace_snooper_monitor.sv
//******************************
// Monitor for the trace snooper
// Samples on the rising edge, expects read data one cycle after a request
//******************************
`timescale 1ns/1ns
`default_nettype none

module trace_snooper_monitor
   import trace_snoop_pkg::*;
#(
   parameter int unsigned AddrWidth = 4
) (
   input  wire  logic                 clk_i,
   input  wire  logic                 rst_ni,
   input  wire  logic                 rd_req_i,
   input  wire  trace_t               exp_data_i,
   input  wire  logic                 rd_valid_i,
   input  wire  trace_t               rd_data_i,
   input  wire  logic                 ptr_chk_i,
   input  wire  logic [AddrWidth-1:0] cnt_i,
   input  wire  logic [AddrWidth-1:0] first_i,
   input  wire  logic [AddrWidth-1:0] last_i,
   input  wire  logic [31:0]          cfg_rdata_i,
   input  wire  logic [AddrWidth-1:0] exp_cnt_i,
   input  wire  logic [AddrWidth-1:0] exp_first_i,
   input  wire  logic [AddrWidth-1:0] exp_last_i,
   input  wire  logic [31:0]          exp_rdata_i,
   input  wire  logic                 test_done_i,
   input  wire  logic [31:0]          test_num_i,
   output       int                   err_cnt_o,
   output       int                   chk_cnt_o,
   output       int                   test_cnt_o
);

   int     err_cnt  = 0;
   int     chk_cnt  = 0;
   int     test_cnt = 0;
   int     err_base = 0;
   int     chk_base = 0;
   logic   pend_q   = 1'b0;
   trace_t exp_q;

   assign err_cnt_o  = err_cnt;
   assign chk_cnt_o  = chk_cnt;
   assign test_cnt_o = test_cnt;

   task automatic compare_word(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   always @(posedge clk_i) begin
      if (!rst_ni) begin
         pend_q = 1'b0;
      end else begin
         // Response to the request taken at the previous edge
         if (pend_q) begin
            if (!rd_valid_i) begin
               err_cnt++;
               $display("At %0t ns a read request got no rd_valid_o one cycle later", $time);
            end else begin
               chk_cnt++;
               if (rd_data_i !== exp_q) begin
                  err_cnt++;
                  $display("[ERROR] %0t ns: read data %h, expected %h",
                           $time, rd_data_i, exp_q);
               end
            end
         end else if (rd_valid_i) begin
            err_cnt++;
            $display("At %0t ns rd_valid_o rose without a read request", $time);
         end
         pend_q = rd_req_i;
         exp_q  = exp_data_i;

         if (ptr_chk_i) begin
            compare_word("cnt_o", 32'(cnt_i), 32'(exp_cnt_i));
            compare_word("first_valid_o", 32'(first_i), 32'(exp_first_i));
            compare_word("last_valid_o", 32'(last_i), 32'(exp_last_i));
            compare_word("cfg_rdata_o", cfg_rdata_i, exp_rdata_i);
         end

         if (test_done_i) begin
            test_cnt++;
            $display("Test %0d done: %0d checks, %0d errors", test_num_i,
                     chk_cnt - chk_base, err_cnt - err_base);
            chk_base = chk_cnt;
            err_base = err_cnt;
         end
      end
   end

endmodule

`default_nettype wire

// File: sim/trace_snooper_tb.sv
//******************************
// Testbench for the trace snooper
// Depth 16, inputs change on the falling edge
// Reads only entries that were written
//******************************
`timescale 1ns/1ns
`default_nettype none

module trace_snooper_tb
   import trace_snoop_pkg::*;
   import snoop_cfg_pkg::*;
();

   localparam int unsigned aw_c      = 4;
   localparam int unsigned depth_c   = 2 ** aw_c;
   // Cycle budget per test, reset and readout included
   localparam int          timeout_c = 10 + 70 + 30 + 50 + 40 + 200;

   typedef logic [aw_c-1:0] entry_t;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        cfg_we;
   cfg_sel_e    cfg_sel;
   logic [31:0] cfg_wdata;
   logic [31:0] cfg_rdata;
   trace_t      trace;
   logic        snoop_en;
   logic        rd_req;
   entry_t      rd_entry;
   logic        rd_valid;
   trace_t      rd_data;
   entry_t      cnt;
   entry_t      first_valid;
   entry_t      last_valid;

   // Expected values handed to the monitor
   trace_t      exp_rd;
   logic        ptr_chk;
   entry_t      exp_cnt;
   entry_t      exp_first;
   entry_t      exp_last;
   logic [31:0] exp_rdata;
   logic        test_done;
   int          test_num;
   int          err_cnt;
   int          chk_cnt;
   int          test_cnt;
   int          total_err;
   int          cycle_cnt = 0;
   int          gap;
   integer      seed;

   // Reference state, one memory per field plus the pointers
   logic [field_width_c-1:0] model_mem [num_fields_c][depth_c];
   entry_t                   model_cnt;
   entry_t                   model_first;
   entry_t                   model_last;
   logic                     model_full;
   trace_mode_e              model_mode;

   trace_snooper #(
      .AddrWidth(aw_c)
   ) uut (
      .clk_i         (clk),
      .rst_ni        (rst_n),
      .cfg_we_i      (cfg_we),
      .cfg_sel_i     (cfg_sel),
      .cfg_wdata_i   (cfg_wdata),
      .cfg_rdata_o   (cfg_rdata),
      .trace_i       (trace),
      .snoop_en_i    (snoop_en),
      .rd_req_i      (rd_req),
      .rd_entry_i    (rd_entry),
      .rd_valid_o    (rd_valid),
      .rd_data_o     (rd_data),
      .cnt_o         (cnt),
      .first_valid_o (first_valid),
      .last_valid_o  (last_valid)
   );

   trace_snooper_monitor #(
      .AddrWidth(aw_c)
   ) u_monitor (
      .clk_i       (clk),
      .rst_ni      (rst_n),
      .rd_req_i    (rd_req),
      .exp_data_i  (exp_rd),
      .rd_valid_i  (rd_valid),
      .rd_data_i   (rd_data),
      .ptr_chk_i   (ptr_chk),
      .cnt_i       (cnt),
      .first_i     (first_valid),
      .last_i      (last_valid),
      .cfg_rdata_i (cfg_rdata),
      .exp_cnt_i   (exp_cnt),
      .exp_first_i (exp_first),
      .exp_last_i  (exp_last),
      .exp_rdata_i (exp_rdata),
      .test_done_i (test_done),
      .test_num_i  (test_num),
      .err_cnt_o   (err_cnt),
      .chk_cnt_o   (chk_cnt),
      .test_cnt_o  (test_cnt)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= timeout_c) begin
         $display("Timeout: the run did not finish within %0d cycles", timeout_c);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   function automatic void model_clear();
      model_cnt   = '0;
      model_first = '0;
      model_last  = '0;
      model_full  = 1'b0;
   endfunction

   // Applies one strobed record to the reference state
   function automatic void model_write(input trace_t rec);
      logic [field_width_c-1:0] words [num_fields_c];
      logic                     wrote;
      words[0] = rec.pc_src_l;
      words[1] = rec.pc_src_h;
      words[2] = rec.pc_dst_l;
      words[3] = rec.pc_dst_h;
      words[4] = rec.metadata;
      wrote    = 1'b1;
      case (model_mode)
         MODE_ADDRESS: begin
            for (int f = 0; f < num_fields_c; f++) begin
               model_mem[f][model_cnt] = words[f];
            end
         end
         MODE_INSTRUCTION: begin
            model_mem[0][model_cnt] = words[0];
         end
         default: begin
            wrote = 1'b0;
         end
      endcase
      if (wrote) begin
         model_last = model_cnt;
         if (model_cnt == entry_t'(depth_c - 1)) begin
            model_full = 1'b1;
         end
         model_cnt = entry_t'(model_cnt + 1);
         if (model_full) begin
            model_first = model_cnt;
         end
      end
   endfunction

   function automatic trace_t model_entry(input entry_t idx);
      trace_t t;
      t.pc_src_l = model_mem[0][idx];
      t.pc_src_h = model_mem[1][idx];
      t.pc_dst_l = model_mem[2][idx];
      t.pc_dst_h = model_mem[3][idx];
      t.metadata = model_mem[4][idx];
      return t;
   endfunction

   function automatic logic [31:0] model_rdata(input cfg_sel_e sel);
      logic [31:0] w;
      w = '0;
      if (sel == CFG_CTRL) begin
         w[1:0] = model_mode;
      end else begin
         w[aw_c-1:0]              = model_cnt;
         w[cfg_status_full_bit_c] = model_full;
      end
      return w;
   endfunction

   function automatic trace_t rand_trace();
      trace_t t;
      t.pc_src_l = $random(seed);
      t.pc_src_h = $random(seed);
      t.pc_dst_l = $random(seed);
      t.pc_dst_h = $random(seed);
      t.metadata = $random(seed);
      return t;
   endfunction

   // All tasks start and end just after a falling edge
   task automatic set_mode(input trace_mode_e mode, input logic clear);
      cfg_we                        = 1'b1;
      cfg_sel                       = CFG_CTRL;
      cfg_wdata                     = '0;
      cfg_wdata[1:0]                = mode;
      cfg_wdata[cfg_ctrl_rst_bit_c] = clear;
      @(negedge clk);
      cfg_we     = 1'b0;
      model_mode = mode;
      if (clear) begin
         // Strobe during the pulse cycle is dropped
         trace    = rand_trace();
         snoop_en = 1'b1;
         @(negedge clk);
         snoop_en = 1'b0;
         model_clear();
      end
   endtask

   task automatic snoop_record(input trace_t rec, input int idle);
      trace    = rec;
      snoop_en = 1'b1;
      model_write(rec);
      @(negedge clk);
      snoop_en = 1'b0;
      repeat (idle) @(negedge clk);
   endtask

   task automatic check_ptrs(input cfg_sel_e sel);
      cfg_sel   = sel;
      exp_cnt   = model_cnt;
      exp_first = model_first;
      exp_last  = model_last;
      exp_rdata = model_rdata(sel);
      ptr_chk   = 1'b1;
      @(negedge clk);
      ptr_chk = 1'b0;
   endtask

   // Back-to-back requests, one per cycle
   task automatic read_range(input int start, input int count);
      for (int i = 0; i < count; i++) begin
         rd_req   = 1'b1;
         rd_entry = entry_t'(start + i);
         exp_rd   = model_entry(entry_t'(start + i));
         @(negedge clk);
      end
      rd_req = 1'b0;
      @(negedge clk);
   endtask

   task automatic end_test(input int num);
      test_num  = num;
      test_done = 1'b1;
      @(negedge clk);
      test_done = 1'b0;
   endtask

   initial begin
      seed      = 32'h97b6fa1a;
      rst_n     = 1'b0;
      cfg_we    = 1'b0;
      cfg_sel   = CFG_CTRL;
      cfg_wdata = '0;
      trace     = '0;
      snoop_en  = 1'b0;
      rd_req    = 1'b0;
      rd_entry  = '0;
      exp_rd    = '0;
      ptr_chk   = 1'b0;
      exp_cnt   = '0;
      exp_first = '0;
      exp_last  = '0;
      exp_rdata = '0;
      test_done = 1'b0;
      test_num  = 0;
      model_mode = MODE_OFF_3;
      model_clear();
      repeat (2) @(negedge clk);
      rst_n = 1'b1;

      // Reset state
      check_ptrs(CFG_CTRL);
      check_ptrs(CFG_STATUS);
      end_test(1);

      // Address mode with random strobe gaps
      set_mode(MODE_ADDRESS, 1'b0);
      for (int i = 0; i < 10; i++) begin
         gap = $unsigned($random(seed)) % 4;
         snoop_record(rand_trace(), gap);
      end
      check_ptrs(CFG_STATUS);
      read_range(0, 10);
      end_test(2);

      // Opcodes over the address records at entries 0 to 3
      set_mode(MODE_INSTRUCTION, 1'b1);
      for (int i = 0; i < 4; i++) begin
         snoop_record(rand_trace(), 1);
      end
      check_ptrs(CFG_STATUS);
      check_ptrs(CFG_CTRL);
      read_range(0, 10);
      end_test(3);

      // Wrap past the bank depth
      set_mode(MODE_ADDRESS, 1'b1);
      for (int i = 0; i < 20; i++) begin
         snoop_record(rand_trace(), 0);
      end
      check_ptrs(CFG_STATUS);
      read_range(0, depth_c);
      end_test(4);

      // Off mode leaves the buffer alone, then a counter reset
      set_mode(MODE_OFF_2, 1'b0);
      for (int i = 0; i < 3; i++) begin
         snoop_record(rand_trace(), 1);
      end
      check_ptrs(CFG_STATUS);
      read_range(0, depth_c);
      set_mode(MODE_OFF_3, 1'b1);
      check_ptrs(CFG_STATUS);
      check_ptrs(CFG_CTRL);
      end_test(5);

      repeat (2) @(negedge clk);
      total_err = err_cnt + uut.u_checker.fail_cnt;
      $display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, chk_cnt, total_err);
      if (total_err == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: trace_snooper.f
source/trace_snoop_pkg.sv
source/snoop_cfg_pkg.sv
source/snoop_cfg_regs.sv
source/snooping_engine.sv
source/trace_bank.sv
source/trace_readout.sv
source/trace_snooper.sv
sim/trace_snooper_checker.sv
sim/trace_snooper_monitor.sv
sim/trace_snooper_tb.sv

// File: Makefile
# Verilator build for the trace snooper
# Any variable can be overridden, e.g. make sim BUILD_DIR=obj

VERILATOR ?= verilator
TOP       ?= trace_snooper_tb
FILELIST  ?= trace_snooper.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= ERRORS FOUND
PASS_MSG  ?= NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	-$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
